//--- compile.f
hdl/monitorPkg.sv
hdl/flagRegs.sv
hdl/pcMonitor.sv
hdl/laneSteer.sv
hdl/testMonitor.sv
sim/tbClock.sv
sim/testMonitor_chk.sv
sim/tbChecker.sv
sim/tbTop.sv

//--- hdl/flagRegs.sv
// Debug flag register with msb/lsb field writes and reads, live status bits and command pulses
`timescale 1ns/1ps

module flagRegs
  import monitorPkg::*;
(
  input  logic                    clk,
  input  logic                    pcFail,
  input  logic                    flagWrite,
  input  logic                    flagRead,
  input  logic [flagIdxWidth-1:0] flagMsb,
  input  logic [flagIdxWidth-1:0] flagLsb,
  input  logic [dataWidth-1:0]    flagValue,
  input  logic                    passStatus,
  input  logic                    failStatus,
  output logic [dataWidth-1:0]    readData,
  output logic                    readValid,
  output logic                    setFailPulse,
  output logic                    disableStuckPulse,
  output logic                    checkToHost
);

  // Only the writable part is stored, bits 0 to 2 come from outside
  logic [flagCount-1:bitFirstWritable] flagStore;

  logic [flagCount-1:0] flagView;  // What a read sees
  logic [flagCount-1:0] hiMask;    // Bits at or below msb
  logic [flagCount-1:0] loMask;    // dataWidth bits starting at lsb
  logic [flagCount-1:0] wrMask;
  logic [flagCount-1:0] wrBits;

  // ----------------------------------------------------------
  // Field masks
  // ----------------------------------------------------------
  always_comb begin
    hiMask = {flagCount{1'b1}} >> (flagIdxWidth'(flagCount - 1) - flagMsb);
    loMask = {{(flagCount - dataWidth){1'b0}}, {dataWidth{1'b1}}} << flagLsb;
    // Empty when msb is below lsb since the two masks do not overlap
    wrMask = hiMask & loMask;
    wrBits = {{(flagCount - dataWidth){1'b0}}, flagValue} << flagLsb;
  end

  assign flagView = {flagStore, failStatus, passStatus, 1'b1};

  // ----------------------------------------------------------
  // Storage and self-clearing commands
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      flagStore <= '0;
    end else begin
      // Command bits live for one cycle only
      flagStore[bitSetFail]      <= 1'b0;
      flagStore[bitDisableStuck] <= 1'b0;
      if (flagWrite) begin
        for (int i = bitFirstWritable; i < flagCount; i++) begin
          if (wrMask[i]) begin
            flagStore[i] <= wrBits[i];
          end
        end
      end
    end
  end

  assign setFailPulse      = flagStore[bitSetFail];
  assign disableStuckPulse = flagStore[bitDisableStuck];
  assign checkToHost       = flagStore[bitCheckToHost];

  // ----------------------------------------------------------
  // Field read, right-aligned with zeros above
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      readValid <= 1'b0;
    end else begin
      readValid <= flagRead;
    end
  end

  always_ff @(posedge clk) begin
    if (flagRead) begin
      readData <= dataWidth'((flagView & hiMask) >> flagLsb);
    end
  end

endmodule

//--- hdl/laneSteer.sv
// Sub-word lane steering for a 64-bit bus: byte mask, replicated write data and read lane
`timescale 1ns/1ps

module laneSteer
  import monitorPkg::*;
(
  input  logic                 clk,
  input  logic                 pcFail,
  input  logic                 accessStrobe,
  input  logic [1:0]           accessSize,
  input  logic [2:0]           accessAddr,
  input  logic [dataWidth-1:0] wrData,
  input  logic [dataWidth-1:0] busRdData,
  output logic [laneCount-1:0] byteMask,
  output logic [dataWidth-1:0] busWrData,
  output logic [dataWidth-1:0] rdData,
  output logic                 laneValid
);

  logic [2:0]           alignedAddr;  // Address with sub-size bits dropped
  logic [laneCount-1:0] sizeMask;
  logic [laneCount-1:0] nextMask;
  logic [dataWidth-1:0] nextWrData;
  logic [dataWidth-1:0] laneShift;
  logic [dataWidth-1:0] nextRdData;

  // ----------------------------------------------------------
  // Combinational steering
  // ----------------------------------------------------------
  always_comb begin
    case (accessSize)
      accByte: begin
        alignedAddr = accessAddr;
        sizeMask    = laneCount'(8'h01);
        nextWrData  = {(dataWidth / 8){wrData[7:0]}};
      end
      accHalf: begin
        alignedAddr = {accessAddr[2:1], 1'b0};
        sizeMask    = laneCount'(8'h03);
        nextWrData  = {(dataWidth / 16){wrData[15:0]}};
      end
      accWord: begin
        alignedAddr = {accessAddr[2], 2'b00};
        sizeMask    = laneCount'(8'h0f);
        nextWrData  = {(dataWidth / 32){wrData[31:0]}};
      end
      default: begin  // Double, whole bus
        alignedAddr = 3'd0;
        sizeMask    = {laneCount{1'b1}};
        nextWrData  = wrData;
      end
    endcase

    nextMask  = sizeMask << alignedAddr;
    laneShift = busRdData >> {alignedAddr, 3'b000};

    // Zero-extend the addressed lane
    case (accessSize)
      accByte: nextRdData = {{(dataWidth - 8){1'b0}}, laneShift[7:0]};
      accHalf: nextRdData = {{(dataWidth - 16){1'b0}}, laneShift[15:0]};
      accWord: nextRdData = {{(dataWidth - 32){1'b0}}, laneShift[31:0]};
      default: nextRdData = laneShift;
    endcase
  end

  // ----------------------------------------------------------
  // Output registers
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      laneValid <= 1'b0;
    end else begin
      laneValid <= accessStrobe;  // One cycle per strobe
    end
  end

  always_ff @(posedge clk) begin
    if (accessStrobe) begin
      byteMask  <= nextMask;
      busWrData <= nextWrData;
      rdData    <= nextRdData;
    end
  end

endmodule

//--- hdl/monitorPkg.sv
// Shared widths, flag bit positions, table indices and limits, imported by every monitor module
package monitorPkg;

  // ----------------------------------------------------------
  // Bus and PC widths
  // ----------------------------------------------------------
  localparam int pcWidth    = 64;
  localparam int pcCmpWidth = 30;  // Low PC bits compared against the table
  localparam int dataWidth  = 64;
  localparam int laneCount  = 8;   // Byte lanes on the bus

  // ----------------------------------------------------------
  // Debug flag register
  // ----------------------------------------------------------
  localparam int flagCount    = 256;
  localparam int flagIdxWidth = 8;

  // Fixed flag bit positions
  localparam int bitCalibDone    = 0;  // Always reads 1
  localparam int bitPass         = 1;  // Read-only status
  localparam int bitFail         = 2;  // Read-only status
  localparam int bitSetFail      = 3;  // Self-clearing command
  localparam int bitDisableStuck = 4;  // Self-clearing command
  localparam int bitCheckToHost  = 5;  // Plain level

  // Lowest bit that a field write can change
  localparam int bitFirstWritable = bitFail + 1;

  // ----------------------------------------------------------
  // Pass/fail address table
  // ----------------------------------------------------------
  localparam int tableDepth    = 5;
  localparam int tableIdxWidth = 3;

  localparam int tblPass    = 0;
  localparam int tblFail    = 1;
  localparam int tblFinish  = 2;  // Counts only when nonzero
  localparam int tblToHost  = 3;  // Nonzero and gated by checkToHost
  localparam int tblAltFail = 4;  // Counts only when nonzero

  // ----------------------------------------------------------
  // Monitor limits
  // ----------------------------------------------------------
  localparam int stuckLimit    = 500;  // Repeats of one PC that mean stuck
  localparam int stuckCntWidth = $clog2(stuckLimit + 1);
  localparam int sleepDelay    = 20;   // Cycles from status latch to sleep
  localparam int sleepCntWidth = $clog2(sleepDelay);

  // ----------------------------------------------------------
  // Access size codes for lane steering
  // ----------------------------------------------------------
  localparam logic [1:0] accByte   = 2'd0;
  localparam logic [1:0] accHalf   = 2'd1;
  localparam logic [1:0] accWord   = 2'd2;
  localparam logic [1:0] accDouble = 2'd3;

endpackage

//--- hdl/pcMonitor.sv
// Retired PC monitor with pass/fail table, stuck-PC checker, status latch and sleep request
`timescale 1ns/1ps

module pcMonitor
  import monitorPkg::*;
(
  input  logic                     clk,
  input  logic                     pcFail,
  input  logic                     tableWrite,
  input  logic [tableIdxWidth-1:0] tableIndex,
  input  logic [pcWidth-1:0]       tableData,
  input  logic                     retireValid,
  input  logic [pcWidth-1:0]       retirePc,
  input  logic                     checkToHost,
  input  logic                     setFailPulse,
  input  logic                     disableStuckPulse,
  output logic                     passStatus,
  output logic                     failStatus,
  output logic                     coreSleep,
  output logic                     pcStuck
);

  logic [pcCmpWidth-1:0]    passFailTbl [tableDepth];
  logic [pcCmpWidth-1:0]    lowPc;
  logic                     passHit;
  logic                     failHit;
  logic [pcWidth-1:0]       lastPc;
  logic [stuckCntWidth-1:0] stuckCnt;
  logic                     stuckDisabled;
  logic                     statusLatched;
  logic                     sleepArmed;
  logic [sleepCntWidth-1:0] sleepCnt;

  // ----------------------------------------------------------
  // Address table
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      for (int i = 0; i < tableDepth; i++) begin
        passFailTbl[i] <= '0;
      end
    end else if (tableWrite && (int'(tableIndex) < tableDepth)) begin
      passFailTbl[tableIndex] <= tableData[pcCmpWidth-1:0];
    end
  end

  // ----------------------------------------------------------
  // Hit detection
  // ----------------------------------------------------------
  assign lowPc = retirePc[pcCmpWidth-1:0];

  always_comb begin
    passHit = retireValid &&
      ((lowPc == passFailTbl[tblPass]) ||
       ((lowPc == passFailTbl[tblFinish]) && (passFailTbl[tblFinish] != '0)) ||
       ((lowPc == passFailTbl[tblToHost]) && (passFailTbl[tblToHost] != '0) && checkToHost));
    failHit = pcStuck || (retireValid &&
      ((lowPc == passFailTbl[tblFail]) ||
       ((lowPc == passFailTbl[tblAltFail]) && (passFailTbl[tblAltFail] != '0))));
  end

  // ----------------------------------------------------------
  // Stuck-PC checker
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      lastPc        <= '0;
      stuckCnt      <= '0;
      stuckDisabled <= 1'b0;
    end else begin
      if (disableStuckPulse) stuckDisabled <= 1'b1;  // Sticky until reset
      if (retireValid) begin
        lastPc <= retirePc;
        if (retirePc != lastPc) begin
          stuckCnt <= '0;
        end else if (stuckCnt < stuckCntWidth'(stuckLimit)) begin
          stuckCnt <= stuckCnt + 1'b1;  // Saturates at the limit
        end
      end
    end
  end

  assign pcStuck = !stuckDisabled && (stuckCnt >= stuckCntWidth'(stuckLimit));

  // ----------------------------------------------------------
  // Status latch and sleep countdown
  // ----------------------------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      passStatus    <= 1'b0;
      failStatus    <= 1'b0;
      statusLatched <= 1'b0;
      sleepArmed    <= 1'b0;
      sleepCnt      <= '0;
      coreSleep     <= 1'b0;
    end else begin
      if (setFailPulse) begin
        // Software verdict overrides any hit
        passStatus <= 1'b0;
        failStatus <= 1'b1;
      end else if (!statusLatched && (passHit || failHit)) begin
        passStatus <= passHit;
        failStatus <= failHit;
      end

      // First hit only, later ones are ignored
      if (!statusLatched && (passHit || failHit)) begin
        statusLatched <= 1'b1;
        sleepArmed    <= !stuckDisabled;
        sleepCnt      <= '0;
      end else if (sleepArmed && !coreSleep) begin
        if (sleepCnt == sleepCntWidth'(sleepDelay - 1)) begin
          coreSleep <= 1'b1;  // Held until reset
        end else begin
          sleepCnt <= sleepCnt + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/testMonitor.sv
// Core test monitor top level joining the flag register, PC monitor and lane steering
`timescale 1ns/1ps

module testMonitor
  import monitorPkg::*;
(
  input  logic                     clk,
  input  logic                     pcFail,
  // Flag access
  input  logic                     flagWrite,
  input  logic                     flagRead,
  input  logic [flagIdxWidth-1:0]  flagMsb,
  input  logic [flagIdxWidth-1:0]  flagLsb,
  input  logic [dataWidth-1:0]     flagValue,
  output logic [dataWidth-1:0]     readData,
  output logic                     readValid,
  // Table load and retire
  input  logic                     tableWrite,
  input  logic [tableIdxWidth-1:0] tableIndex,
  input  logic [pcWidth-1:0]       tableData,
  input  logic                     retireValid,
  input  logic [pcWidth-1:0]       retirePc,
  output logic                     passStatus,
  output logic                     failStatus,
  output logic                     coreSleep,
  output logic                     pcStuck,
  // Lane steering
  input  logic                     accessStrobe,
  input  logic [1:0]               accessSize,
  input  logic [2:0]               accessAddr,
  input  logic [dataWidth-1:0]     wrData,
  input  logic [dataWidth-1:0]     busRdData,
  output logic [laneCount-1:0]     byteMask,
  output logic [dataWidth-1:0]     busWrData,
  output logic [dataWidth-1:0]     rdData,
  output logic                     laneValid
);

  logic setFailPulse;
  logic disableStuckPulse;
  logic checkToHost;

  flagRegs uFlagRegs (
    .clk, .pcFail, .flagWrite, .flagRead, .flagMsb, .flagLsb, .flagValue,
    .passStatus, .failStatus, .readData, .readValid,
    .setFailPulse, .disableStuckPulse, .checkToHost
  );

  pcMonitor uPcMonitor (
    .clk, .pcFail, .tableWrite, .tableIndex, .tableData, .retireValid, .retirePc,
    .checkToHost, .setFailPulse, .disableStuckPulse,
    .passStatus, .failStatus, .coreSleep, .pcStuck
  );

  laneSteer uLaneSteer (
    .clk, .pcFail, .accessStrobe, .accessSize, .accessAddr, .wrData, .busRdData,
    .byteMask, .busWrData, .rdData, .laneValid
  );

endmodule

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal --top-module tbTop -f compile.f \
    -o simTop && ./obj_dir/simTop; } > sim.log 2>&1 || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

//--- sim/tbChecker.sv
// Reference model of the monitor that watches the DUT ports and counts mismatches per area
`timescale 1ns/1ps

module tbChecker
  import monitorPkg::*;
(
  input logic                     clk,
  input logic                     pcFail,
  input logic                     flagWrite,
  input logic                     flagRead,
  input logic [flagIdxWidth-1:0]  flagMsb,
  input logic [flagIdxWidth-1:0]  flagLsb,
  input logic [dataWidth-1:0]     flagValue,
  input logic [dataWidth-1:0]     readData,
  input logic                     readValid,
  input logic                     tableWrite,
  input logic [tableIdxWidth-1:0] tableIndex,
  input logic [pcWidth-1:0]       tableData,
  input logic                     retireValid,
  input logic [pcWidth-1:0]       retirePc,
  input logic                     passStatus,
  input logic                     failStatus,
  input logic                     coreSleep,
  input logic                     pcStuck,
  input logic                     accessStrobe,
  input logic [1:0]               accessSize,
  input logic [2:0]               accessAddr,
  input logic [dataWidth-1:0]     wrData,
  input logic [dataWidth-1:0]     busRdData,
  input logic [laneCount-1:0]     byteMask,
  input logic [dataWidth-1:0]     busWrData,
  input logic [dataWidth-1:0]     rdData,
  input logic                     laneValid
);

  string testName = "reset";
  int    errs [3];  // Flag, lane, status

  logic [255:0] flagModel;
  logic [29:0]  tbl [5];
  logic         passExp, failExp, sleepExp, latched, armed, stuckDis;
  logic         readPend, lanePend, ph, fh, stuckExp;
  logic [63:0]  readExp, lastPc;
  logic [135:0] laneExp;
  logic [29:0]  lowPc;
  int           repCnt, since;

  task automatic checkValue(input int cat, input string what, input logic [63:0] exp,
                            input logic [63:0] act);
    if (exp !== act) begin
      errs[cat]++;
      $display("ERR %s %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  function automatic logic [63:0] fieldRead(logic [255:0] view, int msb, int lsb);
    logic [63:0] r;
    r = '0;
    for (int k = 0; k < 64; k++) begin
      if (lsb + k <= msb && lsb + k < 256) r[k] = view[lsb + k];
    end
    return r;
  endfunction

  function automatic logic [255:0] fieldWrite(logic [255:0] cur, int msb, int lsb,
                                              logic [63:0] v);
    logic [255:0] res;
    int           idx;
    res = cur;
    for (int k = 0; k < 64; k++) begin
      idx = lsb + k;
      if (idx <= msb && idx < 256 && idx >= 3) res[idx] = v[k];  // Bits 0..2 fixed
    end
    return res;
  endfunction

  // Returns {mask, write data, read data}
  function automatic logic [135:0] laneRef(logic [1:0] size, logic [2:0] addr,
                                           logic [63:0] wd, logic [63:0] rd);
    int          bytes;
    int          base;
    logic [7:0]  mask;
    logic [63:0] w;
    logic [63:0] r;
    bytes = 1 << size;
    base  = (int'(addr) / bytes) * bytes;
    mask  = '0;
    w     = '0;
    r     = '0;
    for (int b = 0; b < 8; b++) begin
      if (b >= base && b < base + bytes) begin
        mask[b] = 1'b1;
        r[(b - base) * 8 +: 8] = rd[b * 8 +: 8];
      end
      w[b * 8 +: 8] = wd[(b % bytes) * 8 +: 8];
    end
    return {mask, w, r};
  endfunction

  // ----------------------------------------------------------
  // Compare old outputs, then advance the model
  // ----------------------------------------------------------
  always @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      flagModel = '0;
      foreach (tbl[i]) tbl[i] = '0;
      {passExp, failExp, sleepExp, latched, armed, stuckDis} = '0;
      {readPend, lanePend} = '0;
      lastPc = '0;
      repCnt = 0;
      since  = 0;
    end else begin
      checkValue(0, "readValid", 64'(readPend), 64'(readValid));
      if (readPend) checkValue(0, "readData", readExp, readData);
      checkValue(1, "laneValid", 64'(lanePend), 64'(laneValid));
      if (lanePend) begin
        checkValue(1, "byteMask", 64'(laneExp[135:128]), 64'(byteMask));
        checkValue(1, "busWrData", laneExp[127:64], busWrData);
        checkValue(1, "rdData", laneExp[63:0], rdData);
      end
      checkValue(2, "passStatus", 64'(passExp), 64'(passStatus));
      checkValue(2, "failStatus", 64'(failExp), 64'(failStatus));
      checkValue(2, "coreSleep", 64'(sleepExp), 64'(coreSleep));
      stuckExp = !stuckDis && repCnt >= stuckLimit;
      checkValue(2, "pcStuck", 64'(stuckExp), 64'(pcStuck));

      readPend = flagRead;
      readExp  = fieldRead({flagModel[255:3], failExp, passExp, 1'b1},
                           int'(flagMsb), int'(flagLsb));
      lanePend = accessStrobe;
      laneExp  = laneRef(accessSize, accessAddr, wrData, busRdData);

      lowPc = retirePc[29:0];
      ph = retireValid && (lowPc == tbl[0] || (tbl[2] != 0 && lowPc == tbl[2]) ||
                           (tbl[3] != 0 && flagModel[5] && lowPc == tbl[3]));
      fh = stuckExp || (retireValid && (lowPc == tbl[1] || (tbl[4] != 0 && lowPc == tbl[4])));
      if (flagModel[3]) begin
        passExp = 1'b0;
        failExp = 1'b1;
      end else if (!latched && (ph || fh)) begin
        passExp = ph;
        failExp = fh;
      end
      if (!latched && (ph || fh)) begin
        latched = 1'b1;
        armed   = !stuckDis;
        since   = 0;
      end else if (latched) begin
        since++;
      end
      sleepExp = armed && since >= sleepDelay;

      if (retireValid) begin
        repCnt = (retirePc == lastPc) ? repCnt + 1 : 0;
        lastPc = retirePc;
      end
      if (flagModel[4]) stuckDis = 1'b1;
      if (tableWrite && tableIndex < 5) tbl[tableIndex] = tableData[29:0];

      flagModel[4:3] = 2'b00;  // Commands last one cycle
      if (flagWrite) flagModel = fieldWrite(flagModel, int'(flagMsb), int'(flagLsb), flagValue);
    end
  end

endmodule

//--- sim/tbClock.sv
// Testbench clock source, 40 ns period, with power-on reset held for the first 10 cycles
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic porReset
);

  initial begin
    clk      = 1'b0;
    porReset = 1'b1;
    repeat (10) @(posedge clk);
    #2 porReset = 1'b0;  // Released just after the tenth edge
  end

  always #20 clk = ~clk;

endmodule

//--- sim/tbTop.sv
// Testbench top: drives the monitor through flag, lane, pass/fail, stuck and command sequences
`timescale 1ns/1ps

module tbTop
  import monitorPkg::*;
;

  logic clk, porReset, softReset, pcFail;
  logic flagWrite, flagRead, tableWrite, retireValid, accessStrobe;
  logic [flagIdxWidth-1:0]  flagMsb, flagLsb;
  logic [dataWidth-1:0]     flagValue, readData, wrData, busRdData, busWrData, rdData;
  logic [tableIdxWidth-1:0] tableIndex;
  logic [pcWidth-1:0]       tableData, retirePc;
  logic [1:0]               accessSize;
  logic [2:0]               accessAddr;
  logic [laneCount-1:0]     byteMask;
  logic readValid, passStatus, failStatus, coreSleep, pcStuck, laneValid;
  logic [31:0] seed = 32'hede2_c68c;
  logic [63:0] got;
  int timeouts = 0;
  int n;
  int m;

  assign pcFail = porReset | softReset;

  tbClock uClock (.clk(clk), .porReset(porReset));
  testMonitor i_dut (.*);
  tbChecker uChecker (.*);

  function automatic logic [31:0] lcgNext(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    seed = lcgNext(seed);
    return seed;
  endfunction

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic applyReset();
    softReset = 1'b1;
    step();
    step();
    softReset = 1'b0;
  endtask

  task automatic writeFlag(input int msb, input int lsb, input logic [63:0] val);
    flagMsb   = flagIdxWidth'(msb);
    flagLsb   = flagIdxWidth'(lsb);
    flagValue = val;
    flagWrite = 1'b1;
    step();
    flagWrite = 1'b0;
  endtask

  task automatic readFlag(input int msb, input int lsb, output logic [63:0] val);
    int k;
    flagMsb  = flagIdxWidth'(msb);
    flagLsb  = flagIdxWidth'(lsb);
    flagRead = 1'b1;
    step();
    flagRead = 1'b0;
    k = 0;
    while (!readValid && k < 8) begin
      step();
      k++;
    end
    if (!readValid) begin
      timeouts++;
      $display("Timeout: no read response for a flag read");
    end
    val = readData;
  endtask

  task automatic loadTable(input int idx, input logic [63:0] data);
    tableIndex = tableIdxWidth'(idx);
    tableData  = data;
    tableWrite = 1'b1;
    step();
    tableWrite = 1'b0;
  endtask

  task automatic retireOnce(input logic [63:0] pc);
    retirePc    = pc;
    retireValid = 1'b1;
    step();
    retireValid = 1'b0;
  endtask

  task automatic expectBit(input string what, input logic exp, input logic act);
    uChecker.checkValue(2, what, 64'(exp), 64'(act));
  endtask

  initial begin
    {softReset, flagWrite, flagRead, tableWrite, retireValid, accessStrobe} = '0;
    {flagMsb, flagLsb, tableIndex, accessSize, accessAddr} = '0;
    {flagValue, wrData, busRdData, tableData, retirePc} = '0;
    n = 0;
    do begin
      step();
      n++;
    end while (porReset && n < 20);
    if (porReset) begin
      timeouts++;
      $display("Timeout: power-on reset was never released");
    end

    // ----------------------------------------------------------
    // Field writes and reads
    // ----------------------------------------------------------
    uChecker.testName = "flagField";
    writeFlag(7, 0, 64'hff);  // Low fixed bits must not change
    readFlag(7, 0, got);
    for (int i = 0; i < 200; i++) begin
      n = int'(rand32() >> 24);
      m = n + int'(rand32() >> 26);  // Field of at most 64 bits
      writeFlag((m > 255) ? 255 : m, n, {rand32(), rand32()});
      n = int'(rand32() >> 24);
      m = n + int'(rand32() >> 26);
      readFlag((m > 255) ? 255 : m, n, got);
    end

    uChecker.testName = "laneSteer";
    for (int i = 0; i < 200; i++) begin
      accessSize   = 2'(rand32() >> 30);  // Upper LCG bits, the low ones repeat quickly
      accessAddr   = 3'(rand32() >> 29);
      wrData       = {rand32(), rand32()};
      busRdData    = {rand32(), rand32()};
      accessStrobe = 1'b1;
      step();
      accessStrobe = 1'b0;
      n = 0;
      while (!laneValid && n < 8) begin
        step();
        n++;
      end
      if (!laneValid) begin
        timeouts++;
        $display("Timeout: laneValid never followed accessStrobe");
      end
    end

    // ----------------------------------------------------------
    // Pass through the finish entry and sleep delay
    // ----------------------------------------------------------
    uChecker.testName = "finishPass";
    applyReset();
    loadTable(0, 64'h1000);
    loadTable(1, 64'h2000);
    loadTable(2, 64'h3000);
    retireOnce(64'h3000);
    n = 0;
    while (!coreSleep && n < 40) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!coreSleep) begin
      timeouts++;
      $display("Timeout: coreSleep never rose after the pass hit");
    end
    uChecker.checkValue(2, "sleepDelay", 64'd20, 64'(n));
    #1;
    expectBit("passStatus", 1'b1, passStatus);
    readFlag(1, 1, got);
    expectBit("flagBit1", 1'b1, got[0]);
    retireOnce(64'h2000);
    expectBit("passStatus", 1'b1, passStatus);
    expectBit("failStatus", 1'b0, failStatus);

    uChecker.testName = "altFail";
    applyReset();
    loadTable(4, 64'h4440);
    retireOnce(64'h4440);
    expectBit("failStatus", 1'b1, failStatus);

    uChecker.testName = "toHostGate";
    applyReset();
    loadTable(3, 64'h5550);
    retireOnce(64'h5550);
    expectBit("passStatus", 1'b0, passStatus);
    writeFlag(bitCheckToHost, bitCheckToHost, 64'h1);
    retireOnce(64'h5550);
    expectBit("passStatus", 1'b1, passStatus);

    // ----------------------------------------------------------
    // Stuck PC, enabled then disabled
    // ----------------------------------------------------------
    uChecker.testName = "stuckPc";
    applyReset();
    retirePc    = 64'h6660;
    retireValid = 1'b1;
    repeat (501) step();
    retireValid = 1'b0;
    n = 0;
    while (!failStatus && n < 8) begin
      step();
      n++;
    end
    if (!failStatus) begin
      timeouts++;
      $display("Timeout: failStatus never rose on a stuck PC");
    end
    expectBit("pcStuck", 1'b1, pcStuck);

    uChecker.testName = "stuckDisabled";
    applyReset();
    writeFlag(bitDisableStuck, bitDisableStuck, 64'h1);
    retireValid = 1'b1;
    repeat (501) step();
    retireValid = 1'b0;
    step();
    expectBit("pcStuck", 1'b0, pcStuck);
    expectBit("failStatus", 1'b0, failStatus);

    uChecker.testName = "setFail";
    applyReset();
    loadTable(0, 64'h7770);
    retireOnce(64'h7770);  // Pass verdict first, then the override
    expectBit("passStatus", 1'b1, passStatus);
    writeFlag(bitSetFail, bitSetFail, 64'h1);
    step();
    step();
    expectBit("passStatus", 1'b0, passStatus);
    expectBit("failStatus", 1'b1, failStatus);
    readFlag(bitSetFail, bitSetFail, got);
    expectBit("setFailBit", 1'b0, got[0]);
    step();

    $display("Summary: flag errors %0d, lane errors %0d, status errors %0d, timeouts %0d",
             uChecker.errs[0], uChecker.errs[1], uChecker.errs[2], timeouts);
    if (uChecker.errs[0] + uChecker.errs[1] + uChecker.errs[2] + timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Overall limit on the run
  initial begin
    #1000000;
    $display("Run did not complete within the time limit");
    $display("Something failed");
    $finish;
  end

endmodule

//--- sim/testMonitor_chk.sv
// Concurrent assertions on the monitor ports, bound into every testMonitor instance
`timescale 1ns/1ps

module testMonitorChk (
  input logic clk,
  input logic pcFail,
  input logic flagRead,
  input logic readValid,
  input logic accessStrobe,
  input logic laneValid,
  input logic passStatus,
  input logic failStatus,
  input logic coreSleep
);

  // One read response per read strobe, one cycle later
  readFollowsStrobe: assert property (@(posedge clk) disable iff (pcFail)
    flagRead |=> readValid) else $error("readValid missing after flagRead");
  noStrayRead: assert property (@(posedge clk) disable iff (pcFail)
    !flagRead |=> !readValid) else $error("readValid without flagRead");

  laneFollowsStrobe: assert property (@(posedge clk) disable iff (pcFail)
    accessStrobe |=> laneValid) else $error("laneValid missing after accessStrobe");

  sleepHolds: assert property (@(posedge clk) disable iff (pcFail)
    coreSleep |=> coreSleep) else $error("coreSleep dropped before reset");

  // Sleep only follows a latched verdict
  sleepNeedsVerdict: assert property (@(posedge clk) disable iff (pcFail)
    coreSleep |-> (passStatus || failStatus)) else $error("coreSleep without a verdict");

endmodule

bind testMonitor testMonitorChk uChk (
  .clk(clk), .pcFail(pcFail), .flagRead(flagRead), .readValid(readValid),
  .accessStrobe(accessStrobe), .laneValid(laneValid), .passStatus(passStatus),
  .failStatus(failStatus), .coreSleep(coreSleep)
);
